// ==== Bender.yml ====
package:
  name: hps_io

sources:
  - include_dirs:
      - include
    files:
      - hw/hps_pkg.sv
      - hw/uio_if.sv
      - hw/uio_frame.sv
      - hw/cfg_regs.sv
      - hw/conf_str_rom.sv
      - hw/fio_download.sv
      - hw/hps_io.sv
      - target: simulation
        files:
          - tests/tb_clock.sv
          - tests/hps_io_sva.sv
          - tests/hps_io_tb.sv

// ==== hps_io.f ====
+incdir+include
hw/hps_pkg.sv
hw/uio_if.sv
hw/uio_frame.sv
hw/cfg_regs.sv
hw/conf_str_rom.sv
hw/fio_download.sv
hw/hps_io.sv
tests/tb_clock.sv
tests/hps_io_sva.sv
tests/hps_io_tb.sv

// ==== hw/cfg_regs.sv ====
// user i/o register block
// config bits, joysticks, status word and the status-set request

`default_nettype none

`include "hps_io_settings.svh"

module cfg_regs (
	input wire clk_sys,
	input wire reset,
	input wire hps_pkg::status_t status_in,
	input wire status_set,
	uio_if.regs bus,
	output logic [3:0] stset_cnt,
	output logic [1:0] buttons,
	output logic forced_scandoubler,
	output logic direct_video,
	output hps_pkg::joy_t joystick_0,
	output hps_pkg::joy_t joystick_1,
	output hps_pkg::status_t status
);

	hps_pkg::status_t status_req;
	logic status_set_d;
	// status slice for data words 1 to 4
	logic [1:0] wr_slot;

	assign wr_slot = bus.cnt[1:0] - 2'd1;

	//////////////////////////////////////////////////
	// host writes
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buttons <= '0;
			forced_scandoubler <= 1'b0;
			direct_video <= 1'b0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
		end else if (bus.strobe) begin
			case (bus.cmd)
				`UIO_CFG: begin
					buttons <= bus.din[1:0];
					forced_scandoubler <= bus.din[4];
					direct_video <= bus.din[10];
				end
				`UIO_JOY0: begin
					if (bus.cnt == hps_pkg::cnt_t'(1))
						joystick_0[15:0] <= bus.din;
					else
						joystick_0[31:16] <= bus.din;
				end
				`UIO_JOY1: begin
					if (bus.cnt == hps_pkg::cnt_t'(1))
						joystick_1[15:0] <= bus.din;
					else
						joystick_1[31:16] <= bus.din;
				end
				`UIO_STATUS: begin
					// least significant slice first
					if (bus.cnt >= hps_pkg::cnt_t'(1) && bus.cnt <= hps_pkg::cnt_t'(4))
						status[{wr_slot, 4'b0000} +: 16] <= bus.din;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// status-set request from the core
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_d <= 1'b0;
			stset_cnt <= '0;
			status_req <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				stset_cnt <= stset_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	// the framer sends this on the strobe after index cnt,
	// so slice cnt answers data word cnt+1
	always_comb begin
		bus.rd_data = '0;
		if (bus.cmd == `UIO_STATUS_SET && bus.cnt < hps_pkg::cnt_t'(4))
			bus.rd_data = status_req[{bus.cnt[1:0], 4'b0000} +: 16];
	end

endmodule

`default_nettype wire

// ==== hw/conf_str_rom.sv ====
// configuration string ROM
// one byte per data word, read with one cycle of latency

`default_nettype none

`include "hps_io_settings.svh"

module conf_str_rom #(
	parameter logic [8*`HPS_CONF_LEN-1:0] CONF_STR = "DEMO;;O1,Test;-;"
) (
	input wire clk_sys,
	uio_if.rom bus
);

	localparam int ADDR_W = $clog2(`HPS_CONF_LEN);

	logic [7:0] rom [`HPS_CONF_LEN];

	// first character sits in the top byte of the string
	initial begin
		for (int i = 0; i < `HPS_CONF_LEN; i++) begin
			rom[i] = CONF_STR[8*(`HPS_CONF_LEN-i)-1 -: 8];
		end
	end

	always_ff @(posedge clk_sys) begin
		bus.rom_byte <= (bus.cnt < `HPS_CONF_LEN) ? rom[bus.cnt[ADDR_W-1:0]] : 8'h00;
	end

endmodule

`default_nettype wire

// ==== hw/fio_download.sv ====
// file channel decoder
// file index, extension and bytewide download writes

`default_nettype none

`include "hps_io_settings.svh"

module fio_download (
	input wire clk_sys,
	input wire reset,
	input wire io_strobe,
	input wire fp_enable,
	input wire hps_pkg::word_t io_din,
	output logic ioctl_download,
	output logic ioctl_wr,
	output hps_pkg::word_t ioctl_index,
	output logic [31:0] ioctl_file_ext,
	output hps_pkg::addr_t ioctl_addr,
	output logic [7:0] ioctl_dout
);

	hps_pkg::word_t cmd;
	logic has_cmd;
	// words after the command, saturating
	logic [1:0] cnt;
	// running write address
	hps_pkg::addr_t addr;
	logic wr_pend;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd <= '0;
			has_cmd <= 1'b0;
			cnt <= '0;
			addr <= '0;
			wr_pend <= 1'b0;
			ioctl_wr <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr <= '0;
			ioctl_dout <= '0;
		end else begin
			// write pulse trails the data strobe by two cycles
			ioctl_wr <= wr_pend;
			wr_pend <= 1'b0;
			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd <= io_din;
					has_cmd <= 1'b1;
					cnt <= '0;
				end else begin
					if (~&cnt)
						cnt <= cnt + 1'b1;
					case (cmd)
						`FIO_FILE_INDEX: ioctl_index <= io_din;
						`FIO_FILE_INFO: begin
							if (cnt == 2'd0)
								ioctl_file_ext[31:16] <= io_din;
							else if (cnt == 2'd1)
								ioctl_file_ext[15:0] <= io_din;
						end
						`FIO_FILE_TX: begin
							if (cnt == 2'd0) begin
								if (io_din[7:0] != 8'h00) begin
									addr <= '0;
									ioctl_addr <= '0;
									ioctl_download <= 1'b1;
								end else begin
									ioctl_download <= 1'b0;
								end
							end else if (cnt == 2'd1) begin
								addr[15:0] <= io_din;
								ioctl_addr[15:0] <= io_din;
							end else if (cnt == 2'd2) begin
								addr[`HPS_ADDR_W-1:16] <= io_din[`HPS_ADDR_W-17:0];
								ioctl_addr[`HPS_ADDR_W-1:16] <= io_din[`HPS_ADDR_W-17:0];
							end
						end
						`FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din[7:0];
								wr_pend <= 1'b1;
								addr <= addr + 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/hps_io.sv ====
// host command port of the core
// user i/o channel and file download channel on one strobed word bus

`default_nettype none

`include "hps_io_settings.svh"

module hps_io #(
	parameter logic [8*`HPS_CONF_LEN-1:0] CONF_STR = "DEMO;;O1,Test;-;"
) (
	input wire clk_sys,
	input wire reset,
	input wire io_strobe,
	input wire io_enable,
	input wire fp_enable,
	input wire hps_pkg::word_t io_din,
	input wire hps_pkg::status_t status_in,
	input wire status_set,
	input wire ioctl_wait,
	output hps_pkg::word_t io_dout,
	output logic host_wait,
	output logic [1:0] buttons,
	output logic forced_scandoubler,
	output logic direct_video,
	output hps_pkg::joy_t joystick_0,
	output hps_pkg::joy_t joystick_1,
	output hps_pkg::status_t status,
	output logic ioctl_download,
	output logic ioctl_wr,
	output hps_pkg::word_t ioctl_index,
	output logic [31:0] ioctl_file_ext,
	output hps_pkg::addr_t ioctl_addr,
	output logic [7:0] ioctl_dout
);

	logic [3:0] stset_cnt;

	// host throttles itself on this level
	assign host_wait = ioctl_wait;

	uio_if u_bus (.clk_sys(clk_sys));

	//////////////////////////////////////////////////
	// user i/o channel
	//////////////////////////////////////////////////
	uio_frame u_frame (.clk_sys(clk_sys), .reset(reset), .io_strobe(io_strobe),
		.io_enable(io_enable), .io_din(io_din), .stset_cnt(stset_cnt),
		.io_dout(io_dout), .bus(u_bus.frame));

	cfg_regs u_regs (.clk_sys(clk_sys), .reset(reset), .status_in(status_in),
		.status_set(status_set), .bus(u_bus.regs), .stset_cnt(stset_cnt),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status));

	conf_str_rom #(.CONF_STR(CONF_STR)) u_rom (.clk_sys(clk_sys), .bus(u_bus.rom));

	//////////////////////////////////////////////////
	// file channel
	//////////////////////////////////////////////////
	fio_download u_fio (.clk_sys(clk_sys), .reset(reset), .io_strobe(io_strobe),
		.fp_enable(fp_enable), .io_din(io_din), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout));

endmodule

`default_nettype wire

// ==== hw/hps_pkg.sv ====
// host command port types
// named vectors shared by the framer, registers and file decoder

`default_nettype none

`include "hps_io_settings.svh"

package hps_pkg;

	// one host word
	typedef logic [`HPS_WORD_W-1:0] word_t;

	// word index within a frame, saturating
	typedef logic [`HPS_CNT_W-1:0] cnt_t;

	typedef logic [63:0] status_t;
	typedef logic [31:0] joy_t;
	typedef logic [`HPS_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== hw/uio_frame.sv ====
// user i/o framer
// latches the command, counts data words and registers the reply word

`default_nettype none

`include "hps_io_settings.svh"

module uio_frame (
	input wire clk_sys,
	input wire reset,
	input wire io_strobe,
	input wire io_enable,
	input wire hps_pkg::word_t io_din,
	input wire [3:0] stset_cnt,
	output hps_pkg::word_t io_dout,
	uio_if.frame bus
);

	hps_pkg::word_t cmd;
	// index of the next incoming word, 0 is the command
	hps_pkg::cnt_t word_cnt;
	hps_pkg::word_t reply;

	assign bus.cmd = cmd;

	// reply for a data word
	always_comb begin
		if (cmd == `UIO_CONF_STR) begin
			reply = (word_cnt <= `HPS_CONF_LEN) ? {8'h00, bus.rom_byte} : '0;
		end else begin
			reply = bus.rd_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || !io_enable) begin
			cmd <= '0;
			word_cnt <= '0;
			io_dout <= '0;
			bus.strobe <= 1'b0;
			bus.cnt <= '0;
		end else begin
			bus.strobe <= 1'b0;
			if (io_strobe) begin
				if (~&word_cnt)
					word_cnt <= word_cnt + 1'b1;
				if (word_cnt == '0) begin
					cmd <= io_din;
					// status-set request counter goes out on the command word
					if (io_din == `UIO_STATUS_SET)
						io_dout <= {`HPS_STSET_TAG, 8'h00, stset_cnt};
					else
						io_dout <= '0;
				end else begin
					bus.strobe <= 1'b1;
					bus.cnt <= word_cnt;
					bus.din <= io_din;
					io_dout <= reply;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/uio_if.sv ====
// user i/o word stream
// framer output towards the register block and the config string ROM

`default_nettype none

interface uio_if (
	input wire clk_sys
);

	// registered data strobe, one cycle after the host strobe
	logic strobe;
	// index of the last data word, 0 right after the command
	hps_pkg::cnt_t cnt;
	hps_pkg::word_t cmd;
	hps_pkg::word_t din;

	// replies back to the framer
	hps_pkg::word_t rd_data;
	logic [7:0] rom_byte;

	modport frame (input clk_sys, output strobe, cnt, cmd, din, input rd_data, rom_byte);

	modport regs (input clk_sys, strobe, cnt, cmd, din, output rd_data);

	modport rom (input clk_sys, cnt, output rom_byte);

endinterface

`default_nettype wire

// ==== include/hps_io_settings.svh ====
// host command port settings
// word and counter widths, command codes, config string length

`ifndef HPS_IO_SETTINGS_SVH
`define HPS_IO_SETTINGS_SVH

// widths
`define HPS_WORD_W     16
`define HPS_CNT_W      6
`define HPS_ADDR_W     27
`define HPS_CONF_LEN   16

//////////////////////////////////////////////////
// user i/o channel commands
//////////////////////////////////////////////////
`define UIO_CFG         16'h0001
`define UIO_JOY0        16'h0002
`define UIO_JOY1        16'h0003
`define UIO_CONF_STR    16'h0014
`define UIO_STATUS      16'h001E
`define UIO_STATUS_SET  16'h0029

//////////////////////////////////////////////////
// file channel commands
//////////////////////////////////////////////////
`define FIO_FILE_TX     16'h0053
`define FIO_FILE_TX_DAT 16'h0054
`define FIO_FILE_INDEX  16'h0055
`define FIO_FILE_INFO   16'h0056

// high nibble of the status-set reply
`define HPS_STSET_TAG   4'hA

`endif

// ==== tests/hps_io_sva.sv ====
// host command port assertions
// download write pulses and the idle reply word, bound to the top level

`default_nettype none

module hps_io_sva (
	input wire clk_sys,
	input wire reset,
	input wire io_enable,
	input wire hps_pkg::word_t io_dout,
	input wire ioctl_download,
	input wire ioctl_wr
);

	// assertion failure count
	int fail_cnt = 0;

	// write pulses only inside a download
	wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
	else begin
		$error("ioctl_wr high while ioctl_download is low");
		fail_cnt++;
	end

	// single cycle write pulse
	wr_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr)
	else begin
		$error("ioctl_wr high for more than one cycle");
		fail_cnt++;
	end

	// reply word clears once the frame is closed
	dout_idle_zero: assert property (@(posedge clk_sys) disable iff (reset)
		!io_enable |=> io_dout == '0)
	else begin
		$error("io_dout nonzero outside a user i/o frame");
		fail_cnt++;
	end

endmodule

bind hps_io hps_io_sva u_sva (.*);

`default_nettype wire

// ==== tests/hps_io_tb.sv ====
// host command port testbench
// drives user i/o and file frames, checks replies, registers and writes

`default_nettype none

`include "hps_io_settings.svh"

module hps_io_tb;

	localparam logic [8*`HPS_CONF_LEN-1:0] CONF_TEXT = "TBCORE;;O2,Mode;";
	// word index that asks for the register result of a frame
	localparam int REG_RESULT = -1;
	localparam int DL_BYTES = 10;
	localparam int TIMEOUT = 200;

	wire clk_sys;
	wire reset;
	logic io_strobe;
	logic io_enable;
	logic fp_enable;
	hps_pkg::word_t io_din;
	hps_pkg::status_t status_in;
	logic status_set;
	logic ioctl_wait;

	hps_pkg::word_t io_dout;
	logic host_wait;
	logic [1:0] buttons;
	logic forced_scandoubler;
	logic direct_video;
	hps_pkg::joy_t joystick_0;
	hps_pkg::joy_t joystick_1;
	hps_pkg::status_t status;
	logic ioctl_download;
	logic ioctl_wr;
	hps_pkg::word_t ioctl_index;
	logic [31:0] ioctl_file_ext;
	hps_pkg::addr_t ioctl_addr;
	logic [7:0] ioctl_dout;

	// model state
	logic [15:0] frame_words[$];
	logic [63:0] stset_val;
	int stset_pulses;
	logic [7:0] dl_bytes[DL_BYTES];
	int wr_count;

	// pending comparisons
	string what_q[$];
	logic [63:0] exp_q[$];
	logic [63:0] got_q[$];
	int checks;
	int mismatches;
	int failures;

	tb_clock u_clock (.clk_sys(clk_sys), .reset(reset));

	hps_io #(.CONF_STR(CONF_TEXT)) u_hps_io (.clk_sys(clk_sys), .reset(reset),
		.io_strobe(io_strobe), .io_enable(io_enable), .fp_enable(fp_enable),
		.io_din(io_din), .status_in(status_in), .status_set(status_set),
		.ioctl_wait(ioctl_wait), .io_dout(io_dout), .host_wait(host_wait),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout));

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// reply to word k of a frame, or the register result for REG_RESULT
	function automatic logic [63:0] ref_model(input logic [15:0] cmd, input int k);
		logic [63:0] res;
		res = '0;
		case (cmd)
			`UIO_CFG:
				if (k == REG_RESULT)
					res = {60'd0, frame_words[1][10], frame_words[1][4], frame_words[1][1:0]};
			`UIO_JOY0, `UIO_JOY1:
				if (k == REG_RESULT)
					res = {32'd0, frame_words[2], frame_words[1]};
			`UIO_STATUS:
				if (k == REG_RESULT)
					res = {frame_words[4], frame_words[3], frame_words[2], frame_words[1]};
			`UIO_CONF_STR:
				// first character is the top byte of the literal
				if (k >= 1 && k <= `HPS_CONF_LEN)
					res[7:0] = 8'(CONF_TEXT >> (8 * (`HPS_CONF_LEN - k)));
			`UIO_STATUS_SET:
				if (k == 0)
					res[15:0] = {`HPS_STSET_TAG, 8'h00, 4'(stset_pulses)};
				else if (k >= 1 && k <= 4)
					res[15:0] = 16'(stset_val >> (16 * (k - 1)));
			`FIO_FILE_TX_DAT:
				if (k >= 0 && k < DL_BYTES)
					res = {29'd0, 27'(k), dl_bytes[k]};
			default: ;
		endcase
		return res;
	endfunction

	task automatic expect_value(input string what, input logic [63:0] exp,
		input logic [63:0] got);
		what_q.push_back(what);
		exp_q.push_back(exp);
		got_q.push_back(got);
	endtask

	//////////////////////////////////////////////////
	// host side drivers
	//////////////////////////////////////////////////
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// one strobed word, next strobe three cycles later
	task automatic strobe_word(input logic [15:0] w);
		io_din = w;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		wait_cycles(2);
	endtask

	task automatic send_uio_frame(input logic [15:0] cmd, input int n_data);
		frame_words = {};
		frame_words.push_back(cmd);
		for (int k = 1; k <= n_data; k++)
			frame_words.push_back(16'($urandom()));
		io_enable = 1'b1;
		wait_cycles(1);
		for (int k = 0; k <= n_data; k++) begin
			strobe_word(frame_words[k]);
			// reply is sampled before the next strobe
			expect_value($sformatf("reply %0d to command %h", k, cmd), ref_model(cmd, k),
				64'(io_dout));
		end
		io_enable = 1'b0;
		wait_cycles(2);
	endtask

	// sends frame_words as it stands
	task automatic send_file_frame();
		fp_enable = 1'b1;
		wait_cycles(1);
		foreach (frame_words[k])
			strobe_word(frame_words[k]);
		fp_enable = 1'b0;
		wait_cycles(2);
	endtask

	task automatic pulse_status_set();
		status_set = 1'b1;
		stset_pulses++;
		stset_val = status_in;
		wait_cycles(2);
		status_set = 1'b0;
		wait_cycles(2);
	endtask

	//////////////////////////////////////////////////
	// monitors and comparison
	//////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			if (wr_count < DL_BYTES) begin
				expect_value($sformatf("write %0d address and byte", wr_count),
					ref_model(`FIO_FILE_TX_DAT, wr_count), {29'd0, ioctl_addr, ioctl_dout});
			end else begin
				$display("unexpected write pulse at %0t beyond %0d bytes", $time, DL_BYTES);
				failures++;
			end
			wr_count++;
		end
	end

	always @(negedge clk_sys) begin : compare
		string what;
		logic [63:0] exp;
		logic [63:0] got;
		while (exp_q.size() > 0) begin
			what = what_q.pop_front();
			exp = exp_q.pop_front();
			got = got_q.pop_front();
			checks++;
			if (got !== exp) begin
				mismatches++;
				$display("Mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial begin : stimulus
		logic [15:0] idx;
		logic [15:0] ext_hi;
		logic [15:0] ext_lo;
		logic [15:0] w;
		int t;
		void'($urandom(94));
		io_strobe = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;

		t = 0;
		while (reset !== 1'b0 && t < TIMEOUT) begin
			@(negedge clk_sys);
			t++;
		end
		if (reset !== 1'b0) begin
			$display("reset was never released");
			failures++;
		end
		wait_cycles(2);

		// config word
		send_uio_frame(`UIO_CFG, 1);
		expect_value("config outputs", ref_model(`UIO_CFG, REG_RESULT),
			{60'd0, direct_video, forced_scandoubler, buttons});

		// joysticks and status, low half first
		send_uio_frame(`UIO_JOY0, 2);
		expect_value("joystick_0", ref_model(`UIO_JOY0, REG_RESULT), {32'd0, joystick_0});
		send_uio_frame(`UIO_JOY1, 2);
		expect_value("joystick_1", ref_model(`UIO_JOY1, REG_RESULT), {32'd0, joystick_1});
		send_uio_frame(`UIO_STATUS, 4);
		expect_value("status", ref_model(`UIO_STATUS, REG_RESULT), status);

		// config string, two strobes past its end
		send_uio_frame(`UIO_CONF_STR, `HPS_CONF_LEN + 2);

		// status-set request, new value on the last pulse
		for (int p = 0; p < 3; p++) begin
			if (p == 2)
				status_in = {$urandom(), $urandom()};
			pulse_status_set();
		end
		send_uio_frame(`UIO_STATUS_SET, 5);

		// frame closes with a nonzero reply on the bus
		send_uio_frame(`UIO_STATUS_SET, 0);

		// download setup
		idx = 16'($urandom());
		frame_words = {`FIO_FILE_INDEX, idx};
		send_file_frame();
		ext_hi = 16'($urandom());
		ext_lo = 16'($urandom());
		frame_words = {`FIO_FILE_INFO, ext_hi, ext_lo};
		send_file_frame();
		frame_words = {`FIO_FILE_TX, 16'h0001};
		send_file_frame();
		expect_value("download started", 64'd1, 64'(ioctl_download));

		// data bytes
		frame_words = {`FIO_FILE_TX_DAT};
		for (int i = 0; i < DL_BYTES; i++) begin
			w = 16'($urandom());
			dl_bytes[i] = w[7:0];
			frame_words.push_back(w);
		end
		send_file_frame();
		t = 0;
		while (wr_count < DL_BYTES && t < TIMEOUT) begin
			@(negedge clk_sys);
			t++;
		end
		if (wr_count < DL_BYTES) begin
			$display("timed out with %0d of %0d write pulses seen", wr_count, DL_BYTES);
			failures++;
		end

		// stop and check what stays behind
		frame_words = {`FIO_FILE_TX, 16'h0000};
		send_file_frame();
		expect_value("download stopped", 64'd0, 64'(ioctl_download));
		expect_value("write pulse count", 64'(DL_BYTES), 64'(wr_count));
		expect_value("last write address", 64'(DL_BYTES - 1), 64'(ioctl_addr));
		expect_value("ioctl_index", 64'(idx), 64'(ioctl_index));
		expect_value("ioctl_file_ext", {32'd0, ext_hi, ext_lo}, 64'(ioctl_file_ext));

		// wait level passes straight through
		ioctl_wait = 1'b1;
		wait_cycles(1);
		expect_value("host_wait high", 64'd1, 64'(host_wait));
		ioctl_wait = 1'b0;
		wait_cycles(1);
		expect_value("host_wait low", 64'd0, 64'(host_wait));

		t = 0;
		while (exp_q.size() > 0 && t < TIMEOUT) begin
			@(negedge clk_sys);
			t++;
		end
		if (exp_q.size() > 0) begin
			$display("comparison queue did not drain, %0d left", exp_q.size());
			failures++;
		end

		$display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
			checks, mismatches, failures, u_hps_io.u_sva.fail_cnt);
		if (mismatches == 0 && failures == 0 && u_hps_io.u_sva.fail_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// testbench clock and reset source
// 10 unit period, reset held high over the first two rising edges

`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// release on a falling edge like the rest of the stimulus
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire
